// File: rtl/burst_split_pkg.sv
package burst_split_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ID_WIDTH   = 4;
  localparam int unsigned STRB_WIDTH = DATA_WIDTH / 8;

  // ----------------------------------------
  // Field types and encodings
  // ----------------------------------------
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] burst_t;
  typedef logic [1:0] resp_t;

  localparam burst_t BURST_FIXED = 2'b00;
  localparam burst_t BURST_INCR  = 2'b01;
  localparam burst_t BURST_WRAP  = 2'b10;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ----------------------------------------
  // Channel payloads
  // ----------------------------------------
  // Address channel, shared by AW and AR
  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [ADDR_WIDTH-1:0] addr;
    len_t                  len;
    size_t                 size;
    burst_t                burst;
  } ax_chan_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
    logic [STRB_WIDTH-1:0] strb;
    logic                  last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0] id;
    resp_t               resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_WIDTH-1:0]   id;
    logic [DATA_WIDTH-1:0] data;
    resp_t                 resp;
    logic                  last;
  } r_chan_t;

endpackage

// File: rtl/beat_count_fifo.sv
`timescale 1ns/1ps

module beat_count_fifo #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  burst_split_pkg::len_t push_len_i,
  input  logic                  push_i,
  output logic                  full_o,

  input  logic                  dec_i,
  input  logic                  set_err_i,
  output burst_split_pkg::len_t len_o,
  output logic                  valid_o,
  output logic                  err_o
);
  import burst_split_pkg::*;

  localparam int unsigned IdxWidth = (MaxTxns > 1) ? $clog2(MaxTxns) : 1;
  localparam int unsigned CntWidth = $clog2(MaxTxns + 1);

  typedef logic [IdxWidth-1:0] idx_t;

  // Remaining beats after the current one, per outstanding burst
  len_t                len_mem [MaxTxns];
  logic [MaxTxns-1:0]  err_q;
  idx_t                rd_ptr_q, wr_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                dec, pop;

  // Pointers wrap explicitly so MaxTxns need not be a power of two
  function automatic idx_t next_idx(idx_t idx);
    if (idx == idx_t'(MaxTxns - 1)) begin
      return '0;
    end
    return idx + 1'b1;
  endfunction

  assign valid_o = (count_q != '0);
  assign full_o  = (count_q == CntWidth'(MaxTxns));
  assign len_o   = len_mem[rd_ptr_q];
  // Error seen this cycle counts as well
  assign err_o   = err_q[rd_ptr_q] | set_err_i;

  assign dec = dec_i & valid_o;
  assign pop = dec & (len_o == '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      err_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q        <= next_idx(wr_ptr_q);
        err_q[wr_ptr_q] <= 1'b0;
      end
      if (set_err_i && valid_o) begin
        err_q[rd_ptr_q] <= 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= next_idx(rd_ptr_q);
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Head and tail only coincide when empty or full, so both writes never collide
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      len_mem[wr_ptr_q] <= push_len_i;
    end
    if (dec && !pop) begin
      len_mem[rd_ptr_q] <= len_o - 1'b1;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o)
    else $error("beat_count_fifo: push while full");
  assert property (@(posedge clk_i) disable iff (!rst_n_i) dec_i |-> valid_o)
    else $error("beat_count_fifo: decrement while empty");

endmodule

// File: rtl/ax_splitter.sv
`timescale 1ns/1ps

module ax_splitter #(
  parameter int unsigned MaxTxns = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  // Upstream burst request
  input  burst_split_pkg::ax_chan_t ax_i,
  input  logic                     ax_valid_i,
  output logic                     ax_ready_o,

  // Downstream single-beat requests
  output burst_split_pkg::ax_chan_t ax_o,
  output logic                     ax_valid_o,
  input  logic                     ax_ready_i,

  // Counter port for the response path
  input  logic                     cnt_dec_i,
  input  logic                     cnt_set_err_i,
  output burst_split_pkg::len_t    cnt_len_o,
  output logic                     cnt_valid_o,
  output logic                     cnt_err_o
);
  import burst_split_pkg::*;

  typedef enum logic {IDLE, BUSY} state_e;

  state_e   state_d, state_q;
  ax_chan_t ax_d, ax_q;
  logic     cnt_push, cnt_full;

  function automatic logic [ADDR_WIDTH-1:0] next_addr(ax_chan_t ax);
    if (ax.burst == BURST_INCR) begin
      return ax.addr + (ADDR_WIDTH'(1) << ax.size);
    end
    return ax.addr;
  endfunction

  beat_count_fifo #(
    .MaxTxns (MaxTxns)
  ) i_beat_count_fifo (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .push_len_i (ax_i.len),
    .push_i     (cnt_push),
    .full_o     (cnt_full),
    .dec_i      (cnt_dec_i),
    .set_err_i  (cnt_set_err_i),
    .len_o      (cnt_len_o),
    .valid_o    (cnt_valid_o),
    .err_o      (cnt_err_o)
  );

  always_comb begin
    ax_d       = ax_q;
    state_d    = state_q;
    ax_o       = '0;
    ax_valid_o = 1'b0;
    ax_ready_o = 1'b0;
    cnt_push   = 1'b0;
    unique case (state_q)
      IDLE: begin
        if (ax_valid_i && !cnt_full) begin
          if (ax_i.len == '0) begin
            // Single beat passes straight through
            ax_o       = ax_i;
            ax_valid_o = 1'b1;
            if (ax_ready_i) begin
              cnt_push   = 1'b1;
              ax_ready_o = 1'b1;
            end
          end else begin
            // Take the whole burst now and try to send its first beat
            ax_d       = ax_i;
            cnt_push   = 1'b1;
            ax_ready_o = 1'b1;
            ax_o       = ax_i;
            ax_o.len   = '0;
            ax_valid_o = 1'b1;
            if (ax_ready_i) begin
              ax_d.len  = ax_i.len - 1'b1;
              ax_d.addr = next_addr(ax_i);
            end
            state_d = BUSY;
          end
        end
      end
      BUSY: begin
        ax_o       = ax_q;
        ax_o.len   = '0;
        ax_valid_o = 1'b1;
        if (ax_ready_i) begin
          if (ax_q.len == '0) begin
            state_d = IDLE;
          end else begin
            ax_d.len  = ax_q.len - 1'b1;
            ax_d.addr = next_addr(ax_q);
          end
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    ax_q <= ax_d;
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i) ax_valid_o |-> ax_o.len == '0)
    else $error("ax_splitter: multi-beat request emitted downstream");
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ax_valid_i && ax_ready_o |-> ax_i.burst != BURST_WRAP)
    else $error("ax_splitter: WRAP request accepted");

endmodule

// File: rtl/b_merger.sv
`timescale 1ns/1ps

module b_merger (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  burst_split_pkg::b_chan_t m_b_i,
  input  logic                     m_b_valid_i,
  output logic                     m_b_ready_o,

  output burst_split_pkg::b_chan_t s_b_o,
  output logic                     s_b_valid_o,
  input  logic                     s_b_ready_i,

  input  burst_split_pkg::len_t    cnt_len_i,
  input  logic                     cnt_valid_i,
  input  logic                     cnt_err_i,
  output logic                     cnt_dec_o,
  output logic                     cnt_set_err_o
);
  import burst_split_pkg::*;

  typedef enum logic {B_READY, B_WAIT} state_e;

  state_e state_d, state_q;
  logic   err_d, err_q;

  always_comb begin
    state_d       = state_q;
    err_d         = err_q;
    m_b_ready_o   = 1'b0;
    s_b_o         = m_b_i;
    s_b_valid_o   = 1'b0;
    cnt_dec_o     = 1'b0;
    cnt_set_err_o = 1'b0;
    unique case (state_q)
      B_READY: begin
        if (m_b_valid_i && cnt_valid_i) begin
          cnt_dec_o     = 1'b1;
          cnt_set_err_o = m_b_i.resp[1];
          if (cnt_len_i == '0) begin
            // Final beat of the burst goes upstream
            s_b_valid_o = 1'b1;
            if (cnt_err_i) begin
              s_b_o.resp = RESP_SLVERR;
            end
            if (s_b_ready_i) begin
              m_b_ready_o = 1'b1;
            end else begin
              state_d = B_WAIT;
              err_d   = cnt_err_i;
            end
          end else begin
            // Intermediate response is absorbed
            m_b_ready_o = 1'b1;
          end
        end
      end
      B_WAIT: begin
        s_b_valid_o = m_b_valid_i;
        if (err_q) begin
          s_b_o.resp = RESP_SLVERR;
        end
        if (m_b_valid_i && s_b_ready_i) begin
          m_b_ready_o = 1'b1;
          state_d     = B_READY;
        end
      end
      default: state_d = B_READY;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= B_READY;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

endmodule

// File: rtl/r_last_gen.sv
`timescale 1ns/1ps

module r_last_gen (
  input  logic                     clk_i,
  input  logic                     rst_n_i,

  input  burst_split_pkg::r_chan_t m_r_i,
  input  logic                     m_r_valid_i,
  output logic                     m_r_ready_o,

  output burst_split_pkg::r_chan_t s_r_o,
  output logic                     s_r_valid_o,
  input  logic                     s_r_ready_i,

  input  burst_split_pkg::len_t    cnt_len_i,
  input  logic                     cnt_valid_i,
  output logic                     cnt_dec_o
);

  typedef enum logic {R_FEEDTHROUGH, R_WAIT} state_e;

  state_e state_d, state_q;
  logic   last_d, last_q;

  always_comb begin
    state_d     = state_q;
    last_d      = last_q;
    m_r_ready_o = 1'b0;
    s_r_o       = m_r_i;
    s_r_o.last  = 1'b0;
    s_r_valid_o = 1'b0;
    cnt_dec_o   = 1'b0;
    unique case (state_q)
      R_FEEDTHROUGH: begin
        if (m_r_valid_i && cnt_valid_i) begin
          // Last beat when nothing remains after this one
          last_d      = (cnt_len_i == '0);
          s_r_o.last  = last_d;
          s_r_valid_o = 1'b1;
          cnt_dec_o   = 1'b1;
          if (s_r_ready_i) begin
            m_r_ready_o = 1'b1;
          end else begin
            state_d = R_WAIT;
          end
        end
      end
      R_WAIT: begin
        // Counter already moved on, so replay the stored flag
        s_r_o.last  = last_q;
        s_r_valid_o = m_r_valid_i;
        if (m_r_valid_i && s_r_ready_i) begin
          m_r_ready_o = 1'b1;
          state_d     = R_FEEDTHROUGH;
        end
      end
      default: state_d = R_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= R_FEEDTHROUGH;
      last_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      last_q  <= last_d;
    end
  end

  // A newly arriving beat must find the counter of its burst
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
      m_r_valid_i && state_q == R_FEEDTHROUGH |-> cnt_valid_i)
    else $error("r_last_gen: read beat arrived without a valid counter");

endmodule

// File: rtl/burst_splitter_top.sv
`timescale 1ns/1ps

module burst_splitter_top #(
  parameter int unsigned MaxReadTxns  = 4,
  parameter int unsigned MaxWriteTxns = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  // Upstream port
  input  burst_split_pkg::ax_chan_t s_aw_i,
  input  logic                      s_aw_valid_i,
  output logic                      s_aw_ready_o,
  input  burst_split_pkg::w_chan_t  s_w_i,
  input  logic                      s_w_valid_i,
  output logic                      s_w_ready_o,
  output burst_split_pkg::b_chan_t  s_b_o,
  output logic                      s_b_valid_o,
  input  logic                      s_b_ready_i,
  input  burst_split_pkg::ax_chan_t s_ar_i,
  input  logic                      s_ar_valid_i,
  output logic                      s_ar_ready_o,
  output burst_split_pkg::r_chan_t  s_r_o,
  output logic                      s_r_valid_o,
  input  logic                      s_r_ready_i,

  // Downstream port
  output burst_split_pkg::ax_chan_t m_aw_o,
  output logic                      m_aw_valid_o,
  input  logic                      m_aw_ready_i,
  output burst_split_pkg::w_chan_t  m_w_o,
  output logic                      m_w_valid_o,
  input  logic                      m_w_ready_i,
  input  burst_split_pkg::b_chan_t  m_b_i,
  input  logic                      m_b_valid_i,
  output logic                      m_b_ready_o,
  output burst_split_pkg::ax_chan_t m_ar_o,
  output logic                      m_ar_valid_o,
  input  logic                      m_ar_ready_i,
  input  burst_split_pkg::r_chan_t  m_r_i,
  input  logic                      m_r_valid_i,
  output logic                      m_r_ready_o
);
  import burst_split_pkg::*;

  len_t w_cnt_len, r_cnt_len;
  logic w_cnt_valid, w_cnt_err, w_cnt_dec, w_cnt_set_err;
  logic r_cnt_valid, r_cnt_dec;

  // ----------------------------------------
  // Write path
  // ----------------------------------------
  ax_splitter #(
    .MaxTxns (MaxWriteTxns)
  ) i_aw_splitter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ax_i          (s_aw_i),
    .ax_valid_i    (s_aw_valid_i),
    .ax_ready_o    (s_aw_ready_o),
    .ax_o          (m_aw_o),
    .ax_valid_o    (m_aw_valid_o),
    .ax_ready_i    (m_aw_ready_i),
    .cnt_dec_i     (w_cnt_dec),
    .cnt_set_err_i (w_cnt_set_err),
    .cnt_len_o     (w_cnt_len),
    .cnt_valid_o   (w_cnt_valid),
    .cnt_err_o     (w_cnt_err)
  );

  // Every downstream write is a single beat
  always_comb begin
    m_w_o      = s_w_i;
    m_w_o.last = 1'b1;
  end
  assign m_w_valid_o = s_w_valid_i;
  assign s_w_ready_o = m_w_ready_i;

  b_merger i_b_merger (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .m_b_i         (m_b_i),
    .m_b_valid_i   (m_b_valid_i),
    .m_b_ready_o   (m_b_ready_o),
    .s_b_o         (s_b_o),
    .s_b_valid_o   (s_b_valid_o),
    .s_b_ready_i   (s_b_ready_i),
    .cnt_len_i     (w_cnt_len),
    .cnt_valid_i   (w_cnt_valid),
    .cnt_err_i     (w_cnt_err),
    .cnt_dec_o     (w_cnt_dec),
    .cnt_set_err_o (w_cnt_set_err)
  );

  // ----------------------------------------
  // Read path
  // ----------------------------------------
  ax_splitter #(
    .MaxTxns (MaxReadTxns)
  ) i_ar_splitter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .ax_i          (s_ar_i),
    .ax_valid_i    (s_ar_valid_i),
    .ax_ready_o    (s_ar_ready_o),
    .ax_o          (m_ar_o),
    .ax_valid_o    (m_ar_valid_o),
    .ax_ready_i    (m_ar_ready_i),
    .cnt_dec_i     (r_cnt_dec),
    .cnt_set_err_i (1'b0),
    .cnt_len_o     (r_cnt_len),
    .cnt_valid_o   (r_cnt_valid),
    .cnt_err_o     ()
  );

  r_last_gen i_r_last_gen (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .m_r_i       (m_r_i),
    .m_r_valid_i (m_r_valid_i),
    .m_r_ready_o (m_r_ready_o),
    .s_r_o       (s_r_o),
    .s_r_valid_o (s_r_valid_o),
    .s_r_ready_i (s_r_ready_i),
    .cnt_len_i   (r_cnt_len),
    .cnt_valid_i (r_cnt_valid),
    .cnt_dec_o   (r_cnt_dec)
  );

endmodule

// File: verif/single_beat_sub.sv
`timescale 1ns/1ps

module single_beat_sub #(
  parameter logic [31:0] ErrAddr = 32'h0000_0F00
) (
  input  logic                      clk_i,
  input  logic                      rst_n_i,

  input  burst_split_pkg::ax_chan_t aw_i,
  input  logic                      aw_valid_i,
  output logic                      aw_ready_o,
  input  burst_split_pkg::w_chan_t  w_i,
  input  logic                      w_valid_i,
  output logic                      w_ready_o,
  output burst_split_pkg::b_chan_t  b_o,
  output logic                      b_valid_o,
  input  logic                      b_ready_i,

  input  burst_split_pkg::ax_chan_t ar_i,
  input  logic                      ar_valid_i,
  output logic                      ar_ready_o,
  output burst_split_pkg::r_chan_t  r_o,
  output logic                      r_valid_o,
  input  logic                      r_ready_i
);
  import burst_split_pkg::*;

  localparam int unsigned MemWords = 1024;

  typedef enum logic [1:0] {WR_ADDR, WR_DATA, WR_RESP} wr_state_e;

  wr_state_e             wr_state_q;
  logic [ADDR_WIDTH-1:0] wr_addr_q;
  logic [MemWords-1:0]   written_q;
  logic [DATA_WIDTH-1:0] mem [MemWords];

  function automatic logic [DATA_WIDTH-1:0] read_word(logic [ADDR_WIDTH-1:0] addr);
    if (written_q[addr[11:2]]) begin
      return mem[addr[11:2]];
    end
    // Unwritten words return a pattern built from the full address
    return addr ^ 32'hc3a5_5a3c;
  endfunction

  // ----------------------------------------
  // Write side, one request at a time
  // ----------------------------------------
  assign aw_ready_o = (wr_state_q == WR_ADDR);
  assign w_ready_o  = (wr_state_q == WR_DATA);
  assign b_valid_o  = (wr_state_q == WR_RESP);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_state_q <= WR_ADDR;
      wr_addr_q  <= '0;
      written_q  <= '0;
      b_o        <= '0;
    end else begin
      unique case (wr_state_q)
        WR_ADDR: begin
          if (aw_valid_i) begin
            wr_addr_q  <= aw_i.addr;
            b_o.id     <= aw_i.id;
            wr_state_q <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (w_valid_i) begin
            written_q[wr_addr_q[11:2]] <= 1'b1;
            b_o.resp   <= (wr_addr_q == ErrAddr) ? RESP_SLVERR : RESP_OKAY;
            wr_state_q <= WR_RESP;
          end
        end
        default: begin
          if (b_ready_i) begin
            wr_state_q <= WR_ADDR;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_state_q == WR_DATA && w_valid_i) begin
      for (int b = 0; b < STRB_WIDTH; b++) begin
        if (w_i.strb[b]) begin
          mem[wr_addr_q[11:2]][8*b +: 8] <= w_i.data[8*b +: 8];
        end
      end
    end
  end

  // ----------------------------------------
  // Read side, answered in request order
  // ----------------------------------------
  assign ar_ready_o = !r_valid_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      r_valid_o <= 1'b0;
      r_o       <= '0;
    end else if (r_valid_o) begin
      if (r_ready_i) begin
        r_valid_o <= 1'b0;
      end
    end else if (ar_valid_i) begin
      r_valid_o <= 1'b1;
      r_o.id    <= ar_i.id;
      r_o.data  <= read_word(ar_i.addr);
      r_o.resp  <= (ar_i.addr == ErrAddr) ? RESP_SLVERR : RESP_OKAY;
      r_o.last  <= 1'b1;
    end
  end

endmodule

// File: verif/tb_burst_splitter.sv
`timescale 1ns/1ps

module tb_burst_splitter;
  import burst_split_pkg::*;

  localparam int unsigned Timeout = 1000;
  localparam logic [31:0] ErrAddr = 32'h0000_0F00;

  logic     clk;
  logic     rst_n;
  ax_chan_t s_aw, s_ar, m_aw, m_ar;
  w_chan_t  s_w, m_w;
  b_chan_t  s_b, m_b;
  r_chan_t  s_r, m_r;
  logic     s_aw_valid, s_aw_ready, s_w_valid, s_w_ready;
  logic     s_b_valid, s_b_ready, s_ar_valid, s_ar_ready;
  logic     s_r_valid, s_r_ready;
  logic     m_aw_valid, m_aw_ready, m_w_valid, m_w_ready;
  logic     m_b_valid, m_b_ready, m_ar_valid, m_ar_ready;
  logic     m_r_valid, m_r_ready;

  // Scoreboard state
  string       cur_test;
  int          errors, test_errs, tests_run, tests_failed;
  int          aw_cnt, w_cnt, ar_cnt, b_cnt, r_cnt;
  int          exp_aw_n, exp_ar_n, exp_b_n, exp_r_n;
  int          rd_beats = 1;
  logic [31:0] aw_base, aw_step, ar_base, ar_step;
  resp_t       exp_b_resp;
  logic [31:0] exp_r_data [32];
  logic [31:0] wr_data [16];
  logic [31:0] shadow [1024];
  logic        clr_cnt, count_chk, rand_ready;
  logic [31:0] exp_aw_addr, exp_ar_addr, exp_r_word;
  logic        exp_r_last;

  // Expected address of the next downstream beat
  assign exp_aw_addr = aw_base + aw_step * aw_cnt;
  assign exp_ar_addr = ar_base + ar_step * (ar_cnt % rd_beats);
  assign exp_r_word  = exp_r_data[r_cnt % 32];
  assign exp_r_last  = (r_cnt % rd_beats) == rd_beats - 1;

  initial clk = 1'b0;
  always #2 clk = ~clk;

  burst_splitter_top #(
    .MaxReadTxns  (4),
    .MaxWriteTxns (4)
  ) DUT (
    .clk_i (clk), .rst_n_i (rst_n),
    .s_aw_i (s_aw), .s_aw_valid_i (s_aw_valid), .s_aw_ready_o (s_aw_ready),
    .s_w_i (s_w), .s_w_valid_i (s_w_valid), .s_w_ready_o (s_w_ready),
    .s_b_o (s_b), .s_b_valid_o (s_b_valid), .s_b_ready_i (s_b_ready),
    .s_ar_i (s_ar), .s_ar_valid_i (s_ar_valid), .s_ar_ready_o (s_ar_ready),
    .s_r_o (s_r), .s_r_valid_o (s_r_valid), .s_r_ready_i (s_r_ready),
    .m_aw_o (m_aw), .m_aw_valid_o (m_aw_valid), .m_aw_ready_i (m_aw_ready),
    .m_w_o (m_w), .m_w_valid_o (m_w_valid), .m_w_ready_i (m_w_ready),
    .m_b_i (m_b), .m_b_valid_i (m_b_valid), .m_b_ready_o (m_b_ready),
    .m_ar_o (m_ar), .m_ar_valid_o (m_ar_valid), .m_ar_ready_i (m_ar_ready),
    .m_r_i (m_r), .m_r_valid_i (m_r_valid), .m_r_ready_o (m_r_ready)
  );

  single_beat_sub #(
    .ErrAddr (ErrAddr)
  ) i_sub (
    .clk_i (clk), .rst_n_i (rst_n),
    .aw_i (m_aw), .aw_valid_i (m_aw_valid), .aw_ready_o (m_aw_ready),
    .w_i (m_w), .w_valid_i (m_w_valid), .w_ready_o (m_w_ready),
    .b_o (m_b), .b_valid_o (m_b_valid), .b_ready_i (m_b_ready),
    .ar_i (m_ar), .ar_valid_i (m_ar_valid), .ar_ready_o (m_ar_ready),
    .r_o (m_r), .r_valid_o (m_r_valid), .r_ready_i (m_r_ready)
  );

  // ----------------------------------------
  // Handshake counters and random ready
  // ----------------------------------------
  always @(posedge clk) begin
    if (clr_cnt) begin
      aw_cnt <= 0;
      w_cnt  <= 0;
      ar_cnt <= 0;
      b_cnt  <= 0;
      r_cnt  <= 0;
    end else begin
      if (m_aw_valid && m_aw_ready) aw_cnt <= aw_cnt + 1;
      if (m_w_valid && m_w_ready) w_cnt <= w_cnt + 1;
      if (m_ar_valid && m_ar_ready) ar_cnt <= ar_cnt + 1;
      if (s_b_valid && s_b_ready) b_cnt <= b_cnt + 1;
      if (s_r_valid && s_r_ready) r_cnt <= r_cnt + 1;
    end
  end

  always @(posedge clk) begin
    if (rand_ready) begin
      s_b_ready <= ($urandom & 32'd1) != 0;
      s_r_ready <= ($urandom & 32'd1) != 0;
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  assert property (@(posedge clk) disable iff (!rst_n) m_aw_valid && m_aw_ready |-> m_aw.len == '0)
    else report_mismatch("AW len", 0, $sampled(m_aw.len));
  assert property (@(posedge clk) disable iff (!rst_n)
      m_aw_valid && m_aw_ready |-> m_aw.addr == exp_aw_addr)
    else report_mismatch("AW addr", $sampled(exp_aw_addr), $sampled(m_aw.addr));
  assert property (@(posedge clk) disable iff (!rst_n) m_w_valid && m_w_ready |-> m_w.last)
    else report_mismatch("W last", 1, $sampled(m_w.last));
  assert property (@(posedge clk) disable iff (!rst_n) m_ar_valid && m_ar_ready |-> m_ar.len == '0)
    else report_mismatch("AR len", 0, $sampled(m_ar.len));
  assert property (@(posedge clk) disable iff (!rst_n)
      m_ar_valid && m_ar_ready |-> m_ar.addr == exp_ar_addr)
    else report_mismatch("AR addr", $sampled(exp_ar_addr), $sampled(m_ar.addr));
  assert property (@(posedge clk) disable iff (!rst_n) s_b_valid && s_b_ready |-> s_b.resp == exp_b_resp)
    else report_mismatch("B resp", $sampled(exp_b_resp), $sampled(s_b.resp));
  assert property (@(posedge clk) disable iff (!rst_n) s_r_valid && s_r_ready |-> s_r.last == exp_r_last)
    else report_mismatch("R last", $sampled(exp_r_last), $sampled(s_r.last));
  assert property (@(posedge clk) disable iff (!rst_n) s_r_valid && s_r_ready |-> s_r.data == exp_r_word)
    else report_mismatch("R data", $sampled(exp_r_word), $sampled(s_r.data));
  // Beat counts at the end of each test
  assert property (@(posedge clk) disable iff (!rst_n) count_chk |-> aw_cnt == exp_aw_n)
    else report_mismatch("AW count", $sampled(exp_aw_n), $sampled(aw_cnt));
  assert property (@(posedge clk) disable iff (!rst_n) count_chk |-> w_cnt == exp_aw_n)
    else report_mismatch("W count", $sampled(exp_aw_n), $sampled(w_cnt));
  assert property (@(posedge clk) disable iff (!rst_n) count_chk |-> ar_cnt == exp_ar_n)
    else report_mismatch("AR count", $sampled(exp_ar_n), $sampled(ar_cnt));
  assert property (@(posedge clk) disable iff (!rst_n) count_chk |-> b_cnt == exp_b_n)
    else report_mismatch("B count", $sampled(exp_b_n), $sampled(b_cnt));
  assert property (@(posedge clk) disable iff (!rst_n) count_chk |-> r_cnt == exp_r_n)
    else report_mismatch("R count", $sampled(exp_r_n), $sampled(r_cnt));

  task automatic report_mismatch(string what, logic [31:0] exp_val, logic [31:0] act_val);
    $display("** Error %s %s: expected %0h, actual %0h", cur_test, what, exp_val, act_val);
    errors++;
    test_errs++;
  endtask

  task automatic stop_on_timeout(string what);
    $display("Test %s timed out waiting for %s", cur_test, what);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic start_test(string name);
    cur_test  = name;
    test_errs = 0;
    exp_aw_n  = 0;
    exp_ar_n  = 0;
    exp_b_n   = 0;
    exp_r_n   = 0;
    clr_cnt <= 1'b1;
    @(posedge clk);
    clr_cnt <= 1'b0;
  endtask

  task automatic finish_test();
    count_chk <= 1'b1;
    @(posedge clk);
    count_chk <= 1'b0;
    // Give the count checks one edge to report
    @(posedge clk);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("Test %-12s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "FAILED", test_errs);
  endtask

  // Drives one address request until the DUT takes it
  task automatic drive_addr(logic is_read, ax_chan_t ax);
    int unsigned waited;
    waited = 0;
    if (is_read) begin
      s_ar       <= ax;
      s_ar_valid <= 1'b1;
    end else begin
      s_aw       <= ax;
      s_aw_valid <= 1'b1;
    end
    do begin
      @(posedge clk);
      waited++;
      if (waited > Timeout) stop_on_timeout("address ready");
    end while (is_read ? !s_ar_ready : !s_aw_ready);
    if (is_read) s_ar_valid <= 1'b0;
    else s_aw_valid <= 1'b0;
  endtask

  task automatic drive_w(int unsigned beats);
    int unsigned i;
    int unsigned waited;
    for (i = 0; i < beats; i++) begin
      s_w       <= '{data: wr_data[i], strb: '1, last: (i == beats - 1)};
      s_w_valid <= 1'b1;
      waited = 0;
      do begin
        @(posedge clk);
        waited++;
        if (waited > Timeout) stop_on_timeout("W ready");
      end while (!s_w_ready);
    end
    s_w_valid <= 1'b0;
  endtask

  task automatic wait_for_b(int n);
    int unsigned waited;
    waited = 0;
    while (b_cnt < n) begin
      @(posedge clk);
      waited++;
      if (waited > Timeout) stop_on_timeout("upstream B");
    end
  endtask

  task automatic wait_for_r(int n);
    int unsigned waited;
    waited = 0;
    while (r_cnt < n) begin
      @(posedge clk);
      waited++;
      if (waited > Timeout) stop_on_timeout("upstream R");
    end
  endtask

  // One write burst of size 4 bytes, waits for its merged response
  task automatic write_burst(logic [31:0] addr, int unsigned beats, burst_t burst);
    ax_chan_t    ax;
    logic [31:0] a;
    int unsigned i;
    aw_base    = addr;
    aw_step    = (burst == BURST_INCR) ? (32'd1 << 2) : 32'd0;
    exp_aw_n   = exp_aw_n + beats;
    exp_b_n    = exp_b_n + 1;
    exp_b_resp = RESP_OKAY;
    for (i = 0; i < beats; i++) begin
      a = addr + aw_step * i;
      wr_data[i] = $urandom;
      shadow[a[11:2]] = wr_data[i];
      if (a == ErrAddr) exp_b_resp = RESP_SLVERR;
    end
    ax = '{id: 4'h3, addr: addr, len: len_t'(beats - 1), size: 3'd2, burst: burst};
    fork
      drive_addr(1'b0, ax);
      drive_w(beats);
    join
    wait_for_b(exp_b_n);
  endtask

  task automatic read_burst(logic [31:0] addr, int unsigned beats, burst_t burst);
    ax_chan_t    ax;
    logic [31:0] a;
    int unsigned i;
    ar_base  = addr;
    ar_step  = (burst == BURST_INCR) ? (32'd1 << 2) : 32'd0;
    rd_beats = beats;
    for (i = 0; i < beats; i++) begin
      a = addr + ar_step * i;
      exp_r_data[exp_r_n + i] = shadow[a[11:2]];
    end
    exp_r_n  = exp_r_n + beats;
    exp_ar_n = exp_ar_n + beats;
    ax = '{id: 4'h5, addr: addr, len: len_t'(beats - 1), size: 3'd2, burst: burst};
    drive_addr(1'b1, ax);
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    void'($urandom(32'h67bf));
    rst_n      <= 1'b0;
    s_aw       <= '0;
    s_aw_valid <= 1'b0;
    s_w        <= '0;
    s_w_valid  <= 1'b0;
    s_b_ready  <= 1'b0;
    s_ar       <= '0;
    s_ar_valid <= 1'b0;
    s_r_ready  <= 1'b0;
    clr_cnt    <= 1'b0;
    count_chk  <= 1'b0;
    rand_ready <= 1'b0;
    repeat (3) @(posedge clk);
    rst_n     <= 1'b1;
    s_b_ready <= 1'b1;
    s_r_ready <= 1'b1;
    @(posedge clk);

    start_test("single_rw");
    write_burst(32'h0000_0100, 1, BURST_INCR);
    read_burst(32'h0000_0100, 1, BURST_INCR);
    wait_for_r(exp_r_n);
    finish_test();

    start_test("incr_write");
    write_burst(32'h0000_0200, 8, BURST_INCR);
    finish_test();

    start_test("fixed_read");
    read_burst(32'h0000_0200, 4, BURST_FIXED);
    wait_for_r(exp_r_n);
    finish_test();

    start_test("incr_read");
    read_burst(32'h0000_0200, 8, BURST_INCR);
    wait_for_r(exp_r_n);
    finish_test();

    // Third beat lands on the error address
    start_test("error_write");
    write_burst(32'h0000_0EF8, 4, BURST_INCR);
    finish_test();

    start_test("random_ready");
    rand_ready <= 1'b1;
    write_burst(32'h0000_0400, 6, BURST_INCR);
    read_burst(32'h0000_0400, 6, BURST_INCR);
    read_burst(32'h0000_0400, 6, BURST_INCR);
    wait_for_r(exp_r_n);
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
rtl/burst_split_pkg.sv
rtl/beat_count_fifo.sv
rtl/ax_splitter.sv
rtl/b_merger.sv
rtl/r_last_gen.sv
rtl/burst_splitter_top.sv
verif/single_beat_sub.sv
verif/tb_burst_splitter.sv

// File: Bender.yml
package:
  name: burst_splitter

sources:
  - files:
      - rtl/burst_split_pkg.sv
      - rtl/beat_count_fifo.sv
      - rtl/ax_splitter.sv
      - rtl/b_merger.sv
      - rtl/r_last_gen.sv
      - rtl/burst_splitter_top.sv
  - target: test
    files:
      - verif/single_beat_sub.sv
      - verif/tb_burst_splitter.sv
